//--- filelist.f
+incdir+design
design/armCtrlPkg.sv
design/decodedIf.sv
design/resultIf.sv
design/armDecoder.sv
design/condExecute.sv
design/resultStage.sv
design/armController.sv
testbench/armController_checker.sv
testbench/armController_tb.sv

//--- testbench/armController_tb.sv
`timescale 1ns/1ns
`include "armCtrl_settings.svh"

module armController_tb;
  import armCtrlPkg::*;

  localparam int NUM_DP    = 60;
  localparam int NUM_COND  = 40;
  localparam int NUM_MEM   = 40;
  localparam int NUM_STALL = 80;
  localparam int LIMIT     = (NUM_DP + NUM_COND + NUM_MEM + NUM_STALL) * 8 + 100;

  logic     clk, rstN, instrValid, instrReady, resValid, resReady;
  logic     condPassed, regWrite, memWrite, memToReg, pcWrite;
  instrT    instr;
  flagsT    aluFlags, flags;
  offsetT   addrOffset;
  regIdxT   destReg;
  byteMaskT byteMask;

  flagsT       modelFlags;  // Reference NZCV that moves at acceptance
  logic [12:0] expQ[$];     // {pass, regW, memW, memR, pcW, rd, mask}
  string       testName;
  int          errCount;
  int          cycleCount;
  logic        stallMode;   // Random resReady while set

  armController u_armController (
    .clk (clk), .rstN (rstN), .instrValid (instrValid), .instrReady (instrReady),
    .instr (instr), .aluFlags (aluFlags), .addrOffset (addrOffset),
    .resValid (resValid), .resReady (resReady), .condPassed (condPassed),
    .regWrite (regWrite), .memWrite (memWrite), .memToReg (memToReg),
    .pcWrite (pcWrite), .destReg (destReg), .byteMask (byteMask), .flags (flags)
  );

  bind armController armController_checker u_checker (
    .clk (clk), .rstN (rstN), .instrValid (instrValid), .instrReady (instrReady),
    .resValid (resValid), .resReady (resReady), .condPassed (condPassed),
    .regWrite (regWrite), .memWrite (memWrite), .memToReg (memToReg),
    .pcWrite (pcWrite), .destReg (destReg), .byteMask (byteMask), .flags (flags)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================================
  // Reference model
  // ==========================================================================

  function automatic logic condHolds(input condT c, input flagsT f);
    logic n, z, cy, v, base;
    {n, z, cy, v} = f;
    case (c[3:1])
      3'd0:    base = z;
      3'd1:    base = cy;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = cy && !z;
      3'd5:    base = (n == v);
      3'd6:    base = !z && (n == v);
      default: return c == 4'b1110;  // AL passes and NV never does
    endcase
    return base ^ c[0];  // Odd codes invert the even ones
  endfunction

  task automatic predict(input instrT w, input flagsT af, input offsetT off);
    logic     dp, ls, br, pass, rw, mw, mr, pw;
    aluOpT    op;
    byteMaskT mask;
    op   = w[24:21];
    dp   = (w[27:26] == 2'b00) && !(!w[25] && w[7] && w[4]);
    ls   = (w[27:26] == 2'b01);
    br   = (w[27:26] == 2'b10);
    pass = condHolds(w[31:28], modelFlags);
    rw   = ((dp && !(op inside {[4'd8:4'd11]})) || (ls && w[20])) && pass;
    mw   = ls && !w[20] && pass;
    mr   = ls && w[20] && pass;
    pw   = (br && pass) || (rw && w[15:12] == `PC_REG);
    mask = '0;
    if (ls && pass) begin
      mask = w[22] ? (4'b0001 << off) : 4'b1111;  // Byte lane or whole word
    end
    expQ.push_back({pass, rw, mw, mr, pw, w[15:12], mask});
    if (dp && w[20] && pass) begin
      if (op inside {4'd0, 4'd1, 4'd8, 4'd9, [4'd12:4'd15]}) begin
        modelFlags = {af[3:1], modelFlags[0]};  // Logical ops keep V
      end else begin
        modelFlags = af;
      end
    end
  endtask

  task automatic checkEq(input string field, input logic [15:0] expVal,
                         input logic [15:0] gotVal);
    assert (gotVal === expVal) else begin
      errCount++;
      $display("** Error [%s] %s: expected %0h, actual %0h", testName, field, expVal, gotVal);
    end
  endtask

  // Compare before push since the head is always an older instruction
  always @(posedge clk) begin
    if (rstN) begin
      if (resValid && resReady) begin
        assert (expQ.size() != 0) else begin
          errCount++;
          $display("[%s] record came out with no instruction outstanding", testName);
        end
        if (expQ.size() != 0) begin
          checkEq("record", expQ.pop_front(),
                  {condPassed, regWrite, memWrite, memToReg, pcWrite, destReg, byteMask});
        end
      end
      if (instrValid && instrReady) begin
        predict(instr, aluFlags, addrOffset);
      end
    end
  end

  always @(negedge clk) begin
    resReady = stallMode ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  function automatic instrT makeInstr(input int kind, input int condMode);
    instrT w;
    w = $urandom;
    case (kind)
      0: begin                          // Data processing
        w[27:26] = 2'b00;
        if (!w[25]) w[7] = 1'b0;        // Stay out of multiply/halfword space
      end
      1: w[27:26] = 2'b01;              // Load/store
      2: w[27:25] = 3'b101;             // Branch
      3: begin                          // Excluded class-00 encoding
        w[27:25] = 3'b000;
        w[7] = 1'b1;
        w[4] = 1'b1;
      end
      default: w[27:26] = 2'b11;        // Undecoded class
    endcase
    if ($urandom_range(0, 7) == 0) w[15:12] = 4'hF;  // Hit r15 now and then
    if (condMode == 0) begin
      w[31:28] = ($urandom_range(0, 1) != 0) ? 4'b1110 : condT'($urandom);
    end else begin
      w[31:28] = ($urandom_range(0, 3) == 0) ? 4'b1111 : condT'($urandom);
    end
    return w;
  endfunction

  // Starts and ends on a falling edge
  task automatic sendInstr(input instrT w, input int maxGap);
    instrValid = 1'b1;
    instr      = w;
    aluFlags   = flagsT'($urandom);
    addrOffset = offsetT'($urandom);
    @(posedge clk);
    while (!instrReady) @(posedge clk);
    @(negedge clk);
    instrValid = 1'b0;
    repeat ($urandom_range(0, maxGap)) @(negedge clk);
  endtask

  task automatic runPhase(input string name, input int count, input int kindMax,
                          input int condMode, input logic stall, input int maxGap);
    testName  = name;
    stallMode <= stall;
    for (int i = 0; i < count; i++) begin
      sendInstr(makeInstr($urandom_range(0, kindMax), condMode), maxGap);
    end
    while (expQ.size() != 0) @(negedge clk);  // Drain the pipeline
    checkEq("flags", modelFlags, flags);
  endtask

  initial begin
    void'($urandom(32'h61bf));
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    aluFlags   = '0;
    addrOffset = '0;
    resReady   = 1'b1;
    stallMode  = 1'b0;
    modelFlags = '0;
    errCount   = 0;
    testName   = "reset";
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checkEq("instrReady", 1, instrReady);
    checkEq("resValid", 0, resValid);
    checkEq("enables", 0, {regWrite, memWrite, memToReg, pcWrite, byteMask});
    checkEq("flags", 0, flags);

    runPhase("dataProc", NUM_DP, 0, 0, 1'b0, 0);      // Back to back flag chains
    runPhase("condFail", NUM_COND, 4, 1, 1'b0, 1);
    runPhase("loadStore", NUM_MEM, 2, 0, 1'b0, 1);
    runPhase("backPressure", NUM_STALL, 4, 0, 1'b1, 1);

    $display("Errors: %0d model, %0d checker", errCount, u_armController.u_checker.failCount);
    if (errCount == 0 && u_armController.u_checker.failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Eight cycles per instruction plus slack
  initial begin
    cycleCount = 0;
    while (cycleCount < LIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the pipeline stopped producing records", LIMIT);
    $display("Errors: %0d model, %0d checker", errCount, u_armController.u_checker.failCount);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- testbench/armController_checker.sv
`timescale 1ns/1ns

// Handshake and reset properties on the controller's top-level ports
module armController_checker (
  input logic                 clk,
  input logic                 rstN,
  input logic                 instrValid,
  input logic                 instrReady,
  input logic                 resValid,
  input logic                 resReady,
  input logic                 condPassed,
  input logic                 regWrite,
  input logic                 memWrite,
  input logic                 memToReg,
  input logic                 pcWrite,
  input armCtrlPkg::regIdxT   destReg,
  input armCtrlPkg::byteMaskT byteMask,
  input armCtrlPkg::flagsT    flags
);

  int failCount = 0;  // Failed assertions so far

  // Idle on every reset cycle and on the first cycle after release
  resetIdle: assert property (@(posedge clk) !rstN |=>
      !resValid && instrReady && !condPassed && !regWrite && !memWrite &&
      !memToReg && !pcWrite && byteMask == '0 && flags == '0)
    else begin
      failCount++;
      $error("outputs not idle after a reset cycle");
    end

  // Stalled record must not move
  holdRecord: assert property (@(posedge clk) disable iff (!rstN)
      resValid && !resReady |=> resValid &&
      $stable({condPassed, regWrite, memWrite, memToReg, pcWrite, destReg, byteMask}))
    else begin
      failCount++;
      $error("output record changed while stalled");
    end

  // Three stages, one cycle each, when nothing stalls
  fixedLatency: assert property (@(posedge clk) disable iff (!rstN)
      (instrValid && instrReady) ##1 resReady [*2] |=> resValid)
    else begin
      failCount++;
      $error("record missing three cycles after acceptance");
    end

endmodule

//--- design/armController.sv
`timescale 1ns/1ns

module armController (
  input  logic                 clk,
  input  logic                 rstN,
  // Instruction side
  input  logic                 instrValid,
  output logic                 instrReady,
  input  armCtrlPkg::instrT    instr,
  input  armCtrlPkg::flagsT    aluFlags,     // From the datapath ALU
  input  armCtrlPkg::offsetT   addrOffset,
  // Result side
  output logic                 resValid,
  input  logic                 resReady,
  output logic                 condPassed,
  output logic                 regWrite,
  output logic                 memWrite,
  output logic                 memToReg,
  output logic                 pcWrite,
  output armCtrlPkg::regIdxT   destReg,
  output armCtrlPkg::byteMaskT byteMask,
  output armCtrlPkg::flagsT    flags         // Current NZCV
);

  // ==========================================================================
  // Decode, execute, result
  // ==========================================================================

  decodedIf decIf ();
  resultIf  resIf ();

  armDecoder u_armDecoder (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .instr      (instr),
    .aluFlags   (aluFlags),
    .addrOffset (addrOffset),
    .dec        (decIf.dec)
  );

  condExecute u_condExecute (
    .clk   (clk),
    .rstN  (rstN),
    .dec   (decIf.exe),
    .res   (resIf.exe),
    .flags (flags)
  );

  resultStage u_resultStage (
    .clk        (clk),
    .rstN       (rstN),
    .res        (resIf.res),
    .resValid   (resValid),
    .resReady   (resReady),
    .condPassed (condPassed),
    .regWrite   (regWrite),
    .memWrite   (memWrite),
    .memToReg   (memToReg),
    .pcWrite    (pcWrite),
    .destReg    (destReg),
    .byteMask   (byteMask)
  );

endmodule

//--- design/resultStage.sv
`timescale 1ns/1ns

module resultStage (
  input  logic                 clk,
  input  logic                 rstN,
  resultIf.res                 res,
  // Output record
  output logic                 resValid,
  input  logic                 resReady,
  output logic                 condPassed,
  output logic                 regWrite,
  output logic                 memWrite,
  output logic                 memToReg,
  output logic                 pcWrite,
  output armCtrlPkg::regIdxT   destReg,
  output armCtrlPkg::byteMaskT byteMask
);
  import armCtrlPkg::*;

  byteMaskT maskNext;
  logic     memAccess;   // Load or store that passed its condition
  logic     resXfer;

  // Gated enables already carry the condition result
  assign memAccess = res.memWrite | res.memToReg;

  always_comb begin
    if (!memAccess) begin
      maskNext = '0;
    end else if (res.isByte) begin
      maskNext = byteMaskT'(1) << res.addrOffset;  // One lane
    end else begin
      maskNext = '1;                               // Full word
    end
  end

  assign res.ready = ~resValid | resReady;
  assign resXfer   = res.valid & res.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (res.ready) begin
      resValid <= res.valid;
    end
  end

  // Write enables and lane mask of the presented record
  always_ff @(posedge clk) begin
    if (!rstN) begin
      condPassed <= 1'b0;
      regWrite   <= 1'b0;
      memWrite   <= 1'b0;
      memToReg   <= 1'b0;
      pcWrite    <= 1'b0;
      byteMask   <= '0;
    end else if (resXfer) begin
      condPassed <= res.condPassed;
      regWrite   <= res.regWrite;
      memWrite   <= res.memWrite;
      memToReg   <= res.memToReg;
      pcWrite    <= res.pcWrite;
      byteMask   <= maskNext;
    end
  end

  always_ff @(posedge clk) begin
    if (resXfer) begin
      destReg <= res.destReg;
    end
  end

endmodule

//--- design/condExecute.sv
`timescale 1ns/1ns
`include "armCtrl_settings.svh"

module condExecute (
  input  logic              clk,
  input  logic              rstN,
  decodedIf.exe             dec,
  resultIf.exe              res,
  output armCtrlPkg::flagsT flags   // NZCV register
);
  import armCtrlPkg::*;

  condT   cond;
  logic   condOk;
  logic   flagN, flagZ, flagC, flagV;
  logic   decXfer;
  logic   regWriteGated;
  regIdxT destIdx;

  assign cond = dec.instr[31:28];
  assign {flagN, flagZ, flagC, flagV} = flags;
  assign destIdx = dec.instr[15:12];

  // ==========================================================================
  // Condition check against the current flags
  // ==========================================================================

  always_comb begin
    case (cond)
      4'b0000: condOk = flagZ;                        // EQ
      4'b0001: condOk = ~flagZ;                       // NE
      4'b0010: condOk = flagC;                        // CS
      4'b0011: condOk = ~flagC;                       // CC
      4'b0100: condOk = flagN;                        // MI
      4'b0101: condOk = ~flagN;                       // PL
      4'b0110: condOk = flagV;                        // VS
      4'b0111: condOk = ~flagV;                       // VC
      4'b1000: condOk = flagC & ~flagZ;               // HI
      4'b1001: condOk = ~flagC | flagZ;               // LS
      4'b1010: condOk = (flagN == flagV);             // GE
      4'b1011: condOk = (flagN != flagV);             // LT
      4'b1100: condOk = ~flagZ & (flagN == flagV);    // GT
      4'b1101: condOk = flagZ | (flagN != flagV);     // LE
      4'b1110: condOk = 1'b1;                         // AL
      default: condOk = 1'b0;                         // NV
    endcase
  end

  // ==========================================================================
  // Handshake and stage register
  // ==========================================================================

  assign dec.ready = ~res.valid | res.ready;
  assign decXfer   = dec.valid & dec.ready;

  assign regWriteGated = dec.writesReg & condOk;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      res.valid <= 1'b0;
    end else if (dec.ready) begin
      res.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (decXfer) begin
      res.condPassed <= condOk;
      res.regWrite   <= regWriteGated;
      res.memWrite   <= dec.isLoadStore & ~dec.isLoad & condOk;
      res.memToReg   <= dec.isLoad & condOk;
      // Taken branch, or result written straight into r15
      res.pcWrite    <= (dec.isBranch & condOk) |
                        (regWriteGated & (destIdx == regIdxT'(`PC_REG)));
      res.destReg    <= destIdx;
      res.isByte     <= dec.isByte;
      res.addrOffset <= dec.addrOffset;
    end
  end

  // Updated on the transfer edge, so the next word sees the new flags
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (decXfer && dec.isDataProc && dec.setsFlags && condOk) begin
      if (dec.isLogical) begin
        flags <= {dec.aluFlags[3:1], flagV};  // Shifter carry, V untouched
      end else begin
        flags <= dec.aluFlags;
      end
    end
  end

endmodule

//--- design/armDecoder.sv
`timescale 1ns/1ns

module armDecoder (
  input  logic               clk,
  input  logic               rstN,
  // Instruction stream from the datapath
  input  logic               instrValid,
  output logic               instrReady,
  input  armCtrlPkg::instrT  instr,
  input  armCtrlPkg::flagsT  aluFlags,
  input  armCtrlPkg::offsetT addrOffset,
  // Decoded control towards execute
  decodedIf.dec              dec
);
  import armCtrlPkg::*;

  logic  [1:0] instrClass;    // Bits 27:26
  aluOpT       opcode;
  logic        dpExcluded;    // Multiply and halfword space
  logic        isCompare;     // TST TEQ CMP CMN
  logic        dpNext;
  logic        lsNext;
  logic        brNext;
  logic        logicalNext;
  logic        writesRegNext;
  logic        inXfer;

  // ==========================================================================
  // Classification
  // ==========================================================================

  assign instrClass = instr[27:26];
  assign opcode     = instr[24:21];

  // Register form with bits 7 and 4 both set is not data processing
  assign dpExcluded = ~instr[25] & instr[7] & instr[4];

  assign dpNext = (instrClass == 2'b00) & ~dpExcluded;
  assign lsNext = (instrClass == 2'b01);
  assign brNext = (instrClass == 2'b10);  // Class 11 falls through as none

  assign isCompare = (opcode[3:2] == 2'b10);  // 1000 to 1011

  always_comb begin
    case (opcode)
      4'b0000, 4'b0001,                    // AND EOR
      4'b1000, 4'b1001,                    // TST TEQ
      4'b1100, 4'b1101,                    // ORR MOV
      4'b1110, 4'b1111: logicalNext = 1'b1;  // BIC MVN
      default:          logicalNext = 1'b0;  // Arithmetic
    endcase
  end

  // Loads write Rd, stores and compares never do
  assign writesRegNext = (dpNext & ~isCompare) | (lsNext & instr[20]);

  // ==========================================================================
  // Stage register
  // ==========================================================================

  // Free when empty or when execute takes the current word
  assign instrReady = ~dec.valid | dec.ready;
  assign inXfer     = instrValid & instrReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dec.valid <= 1'b0;
    end else if (instrReady) begin
      dec.valid <= instrValid;  // Bubble when nothing arrives
    end
  end

  // Payload changes only on an accepted word so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (inXfer) begin
      dec.instr       <= instr;
      dec.aluFlags    <= aluFlags;
      dec.addrOffset  <= addrOffset;
      dec.isDataProc  <= dpNext;
      dec.isLoadStore <= lsNext;
      dec.isBranch    <= brNext;
      dec.writesReg   <= writesRegNext;
      dec.setsFlags   <= instr[20];              // S bit
      dec.isLogical   <= dpNext & logicalNext;
      dec.isLoad      <= lsNext & instr[20];     // L bit
      dec.isByte      <= lsNext & instr[22];     // B bit
    end
  end

endmodule

//--- design/resultIf.sv
`timescale 1ns/1ns

// Execute to result link, write enables already gated by the condition
interface resultIf;
  import armCtrlPkg::*;

  logic   valid;
  logic   ready;

  logic   condPassed;
  logic   regWrite;
  logic   memWrite;
  logic   memToReg;    // Load data goes to the register file
  logic   pcWrite;     // Branch taken or write to r15
  regIdxT destReg;
  logic   isByte;      // Byte access, lane picked by addrOffset
  offsetT addrOffset;

  modport exe (
    output valid, condPassed, regWrite, memWrite, memToReg,
    output pcWrite, destReg, isByte, addrOffset,
    input  ready
  );

  modport res (
    input  valid, condPassed, regWrite, memWrite, memToReg,
    input  pcWrite, destReg, isByte, addrOffset,
    output ready
  );

endinterface

//--- design/decodedIf.sv
`timescale 1ns/1ns

// Decode to execute link, one decoded instruction per transfer
interface decodedIf;
  import armCtrlPkg::*;

  logic  valid;        // Payload below is meaningful
  logic  ready;        // Execute can take it this cycle

  instrT instr;        // Raw word, execute still needs cond and Rd
  flagsT aluFlags;     // Datapath flags for this instruction
  offsetT addrOffset;  // Low address bits for byte lanes

  logic  isDataProc;
  logic  isLoadStore;
  logic  isBranch;
  logic  writesReg;    // Ungated register write
  logic  setsFlags;    // S bit of a data-processing op
  logic  isLogical;    // Logical ops keep V
  logic  isLoad;
  logic  isByte;

  modport dec (
    output valid, instr, aluFlags, addrOffset,
    output isDataProc, isLoadStore, isBranch, writesReg,
    output setsFlags, isLogical, isLoad, isByte,
    input  ready
  );

  modport exe (
    input  valid, instr, aluFlags, addrOffset,
    input  isDataProc, isLoadStore, isBranch, writesReg,
    input  setsFlags, isLogical, isLoad, isByte,
    output ready
  );

endinterface

//--- design/armCtrlPkg.sv
`include "armCtrl_settings.svh"

package armCtrlPkg;

  // Whole instruction word as fetched
  typedef logic [`INSTR_W-1:0]   instrT;

  // Condition field in bits 31:28
  typedef logic [3:0]            condT;

  // Status flags, N at the top, V at the bottom
  typedef logic [`FLAG_W-1:0]    flagsT;

  // Data-processing opcode in bits 24:21
  typedef logic [3:0]            aluOpT;

  // Register file index
  typedef logic [`REG_IDX_W-1:0] regIdxT;

  // One bit per byte lane of the data bus
  typedef logic [`MASK_W-1:0]    byteMaskT;

  // Low two bits of the effective address
  typedef logic [`OFFSET_W-1:0]  offsetT;

endpackage

//--- design/armCtrl_settings.svh
`ifndef ARMCTRL_SETTINGS_SVH
`define ARMCTRL_SETTINGS_SVH

// ==========================================================================
// Widths fixed by the ARM instruction set
// ==========================================================================

`define INSTR_W    32  // Instruction word
`define FLAG_W     4   // N Z C V
`define REG_IDX_W  4   // r0..r15
`define MASK_W     4   // One enable per byte lane

// Register number that aliases the program counter
`define PC_REG     15

// Low address bits select a byte lane
`define OFFSET_W   2

`endif
